// ==== Makefile ====
# Verilator build and run for the UPS analog core testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_ups
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the run output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_clk_gen.sv ====
// -----------------------------------------------
// Testbench clock source
// Free running clock, 4 ns period by default
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD = 4.0                         // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                                     // First rise at half a period
        forever begin
            #(PERIOD / 2.0);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_ups.sv ====
// -----------------------------------------------
// UPS analog core testbench
// ADC device model, DAC frame decoder, stimulus
// table with expected codes, watchdog
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ups;

    localparam int NUM_ROWS   = 21;
    localparam int FULL_CODE  = 4095;                   // Largest 12 bit code
    localparam int FRAME_WAIT = 400;                    // Cycles to wait for a DAC frame
    localparam int SETTLE_CYC = 180;                    // Drain in flight and owed frames
    localparam int QUIET_CYC  = 150;                    // Over two ADC frames
    localparam logic [1:0] ADDR_MODE  = 2'd0;
    localparam logic [1:0] ADDR_DAC0  = 2'd1;
    localparam logic [1:0] ADDR_DAC1  = 2'd2;
    localparam logic [1:0] ADDR_VALVE = 2'd3;

    typedef struct packed {
        logic [1:0]  addr;
        logic [31:0] data;
        logic        rnd;                               // Draw a random ADC sample
        logic [11:0] sample;
        logic        frame;                             // DAC frame expected
        logic [11:0] exp0;
        logic [11:0] exp1;
        logic        valve;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   reg_wr;
    logic [1:0]             reg_addr;
    ups_pkg::reg_word_t     reg_wdata;
    logic                   adc_din;
    logic                   adc_sclk;
    logic                   adc_cs_n;
    logic                   dac_sclk;
    logic                   dac_cs_n;
    logic                   dac_dout0;
    logic                   dac_dout1;
    logic                   valve;

    row_t                   rows [NUM_ROWS];
    logic [11:0]            adc_sample;                 // Sample the ADC model sends
    logic [15:0]            adc_word;
    int                     bi;
    int                     errors = 0;
    int                     checks = 0;
    int                     dac_starts = 0;             // DAC frames begun so far
    int                     adc_starts = 0;
    logic [15:0]            dec0;
    logic [15:0]            dec1;
    int                     dec_bits;
    int                     dec_idx;
    logic                   dec_done;
    logic [11:0]            got0_q [$];                 // Decoded frames
    logic [11:0]            got1_q [$];
    int                     got_idx_q [$];
    int                     seed_val;

    tb_clk_gen #(.PERIOD(4.0)) clk_gen0 (.clk(clk));

    ups #(
        .SCLK_DIV  (2)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .adc_din   (adc_din),
        .adc_sclk  (adc_sclk),
        .adc_cs_n  (adc_cs_n),
        .dac_sclk  (dac_sclk),
        .dac_cs_n  (dac_cs_n),
        .dac_dout0 (dac_dout0),
        .dac_dout1 (dac_dout1),
        .valve     (valve)
    );

    // -----------------------------------------------
    // Checks and bus tasks
    // -----------------------------------------------
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr    = 1'b0;                               // Single cycle strobe
    endtask

    // Takes the first frame that began at or after mark
    task automatic wait_frame(input int mark, input logic [11:0] exp0,
                              input logic [11:0] exp1);
        int          waited;
        int          idx;
        logic        found;
        logic [11:0] code0;
        logic [11:0] code1;
        waited = 0;
        found  = 1'b0;
        while (!found && (waited < FRAME_WAIT)) begin
            if (got_idx_q.size() > 0) begin
                idx   = got_idx_q.pop_front();
                code0 = got0_q.pop_front();
                code1 = got1_q.pop_front();
                if (idx >= mark) begin                  // Older frames carry stale codes
                    found = 1'b1;
                    compare_value("dac_dout0 code", code0, exp0);
                    compare_value("dac_dout1 code", code1, exp1);
                end
            end else begin
                @(posedge clk);
                waited++;
            end
        end
        if (!found) begin
            errors++;
            $display("No DAC frame arrived within %0d cycles of the stimulus", FRAME_WAIT);
        end
    endtask

    task automatic expect_quiet();
        int mark;
        int adc_mark;
        repeat (SETTLE_CYC) @(posedge clk);
        #1;
        mark     = dac_starts;
        adc_mark = adc_starts;
        repeat (QUIET_CYC) @(posedge clk);
        #1;
        compare_value("dac_cs_n frame count", dac_starts - mark, 0);
        if (adc_starts - adc_mark < 2) begin
            errors++;
            $display("ADC frames stopped while the DAC was expected to stay quiet");
        end
    endtask

    task automatic apply_row(input int r);
        logic [11:0] s;
        logic [11:0] e0;
        logic [11:0] e1;
        int          mark;
        s  = rows[r].sample;
        e0 = rows[r].exp0;
        e1 = rows[r].exp1;
        if (rows[r].rnd) begin                          // Follow rule: S and its complement
            s  = 12'($urandom % 4096);
            e0 = s;
            e1 = 12'(FULL_CODE - s);
        end
        adc_sample = s;
        mark = dac_starts;
        write_reg(rows[r].addr, rows[r].data);
        if (rows[r].frame && (rows[r].addr == ADDR_MODE)) begin
            // Let one whole ADC frame carry the new sample
            @(negedge adc_cs_n);
            @(posedge adc_cs_n);
            repeat (4) @(posedge clk);
            #1;
            mark = dac_starts;
            wait_frame(mark, e0, e1);
        end else if (rows[r].frame) begin
            wait_frame(mark, e0, e1);
        end else begin
            expect_quiet();
        end
        compare_value("valve", valve, rows[r].valve);
    endtask

    // -----------------------------------------------
    // Stimulus table
    // -----------------------------------------------
    // addr, data, rnd, sample, frame, dac0, dac1, valve
    task automatic load_table();
        rows[0]  = '{ADDR_VALVE, 32'h0000_0000, 1'b0, 12'h123, 1'b0, 12'h000, 12'h000, 1'b0};
        rows[1]  = '{ADDR_VALVE, 32'h0000_0001, 1'b0, 12'h456, 1'b0, 12'h000, 12'h000, 1'b1};
        rows[2]  = '{ADDR_VALVE, 32'h0000_0000, 1'b0, 12'h789, 1'b0, 12'h000, 12'h000, 1'b0};
        rows[3]  = '{ADDR_MODE,  32'h0000_0001, 1'b0, 12'h321, 1'b0, 12'h000, 12'h000, 1'b0};
        rows[4]  = '{ADDR_DAC0,  32'h1234_5ABC, 1'b0, 12'h321, 1'b1, 12'hABC, 12'h000, 1'b0};
        rows[5]  = '{ADDR_DAC1,  32'h0000_05A5, 1'b0, 12'h321, 1'b1, 12'hABC, 12'h5A5, 1'b0};
        rows[6]  = '{ADDR_DAC0,  32'h0000_0FFF, 1'b0, 12'h321, 1'b1, 12'hFFF, 12'h5A5, 1'b0};
        rows[7]  = '{ADDR_DAC1,  32'hFFFF_F001, 1'b0, 12'h321, 1'b1, 12'hFFF, 12'h001, 1'b0};
        rows[8]  = '{ADDR_VALVE, 32'h0000_0001, 1'b0, 12'h321, 1'b0, 12'h000, 12'h000, 1'b1};
        rows[9]  = '{ADDR_MODE,  32'hA5A5_0002, 1'b0, 12'h800, 1'b1, 12'h800, 12'h7FF, 1'b1};
        rows[10] = '{ADDR_MODE,  32'h0000_0002, 1'b0, 12'h000, 1'b1, 12'h000, 12'hFFF, 1'b1};
        rows[11] = '{ADDR_MODE,  32'h0000_0002, 1'b0, 12'hFFF, 1'b1, 12'hFFF, 12'h000, 1'b1};
        rows[12] = '{ADDR_MODE,  32'h0000_0002, 1'b0, 12'h3C7, 1'b1, 12'h3C7, 12'hC38, 1'b1};
        rows[13] = '{ADDR_MODE,  32'h0000_0002, 1'b1, 12'h000, 1'b1, 12'h000, 12'h000, 1'b1};
        rows[14] = '{ADDR_MODE,  32'h0000_0002, 1'b1, 12'h000, 1'b1, 12'h000, 12'h000, 1'b1};
        rows[15] = '{ADDR_MODE,  32'h0000_0002, 1'b1, 12'h000, 1'b1, 12'h000, 12'h000, 1'b1};
        rows[16] = '{ADDR_MODE,  32'h0000_0002, 1'b1, 12'h000, 1'b1, 12'h000, 12'h000, 1'b1};
        rows[17] = '{ADDR_MODE,  32'h0000_0003, 1'b0, 12'h2AA, 1'b0, 12'h000, 12'h000, 1'b1};
        rows[18] = '{ADDR_MODE,  32'h0000_0002, 1'b0, 12'h155, 1'b1, 12'h155, 12'hEAA, 1'b1};
        rows[19] = '{ADDR_MODE,  32'h0000_0000, 1'b0, 12'h0F0, 1'b0, 12'h000, 12'h000, 1'b1};
        rows[20] = '{ADDR_VALVE, 32'hFFFF_FFFE, 1'b0, 12'h0F0, 1'b0, 12'h000, 12'h000, 1'b0};
    endtask

    // -----------------------------------------------
    // ADC device model, four zeros then the sample
    // -----------------------------------------------
    always begin : adc_model
        @(negedge adc_cs_n);
        adc_starts++;
        adc_word = {4'b0000, adc_sample};
        for (bi = 15; bi >= 0; bi--) begin
            #1;
            adc_din = adc_word[bi];                     // MSB first
            @(posedge adc_sclk);
            if (bi > 0) begin
                @(negedge adc_sclk);
            end
        end
    end

    // -----------------------------------------------
    // DAC frame decoder
    // -----------------------------------------------
    always begin : dac_decoder
        @(negedge dac_cs_n);
        dec_idx = dac_starts;                           // Frame number
        dac_starts++;
        dec_bits = 0;
        dec0     = '0;
        dec1     = '0;
        dec_done = 1'b0;
        while (!dec_done) begin
            @(posedge dac_sclk or posedge dac_cs_n);
            if (dac_cs_n) begin
                dec_done = 1'b1;
            end else begin
                dec0 = {dec0[14:0], dac_dout0};
                dec1 = {dec1[14:0], dac_dout1};
                dec_bits++;
            end
        end
        compare_value("dac_sclk bits per frame", dec_bits, 16);
        compare_value("dac_dout0 lead bits", dec0[15:12], 4'h0);
        compare_value("dac_dout1 lead bits", dec1[15:12], 4'h0);
        got0_q.push_back(dec0[11:0]);
        got1_q.push_back(dec1[11:0]);
        got_idx_q.push_back(dec_idx);
    end

    // Budget of 2 us per row
    initial begin : watchdog
        #(NUM_ROWS * 2000);
        $display("Watchdog expired before the stimulus table completed");
        $display("Test failures found");
        $finish;
    end

    // -----------------------------------------------
    // Main sequence
    // -----------------------------------------------
    initial begin : main
        rst        = 1'b1;
        reg_wr     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        adc_din    = 1'b0;
        adc_sample = '0;
        seed_val   = $urandom(32'hee33_5830);
        load_table();
        repeat (3) @(posedge clk);
        #1;
        compare_value("adc_cs_n", adc_cs_n, 1);         // Idle levels in reset
        compare_value("dac_cs_n", dac_cs_n, 1);
        compare_value("adc_sclk", adc_sclk, 1);
        compare_value("dac_sclk", dac_sclk, 1);
        compare_value("dac_dout0", dac_dout0, 0);
        compare_value("dac_dout1", dac_dout1, 0);
        compare_value("valve", valve, 0);
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/ups_pkg.sv
verilog/ups_regs.sv
verilog/ups_ctrl.sv
verilog/ups_ad.sv
verilog/ups_da.sv
verilog/ups.sv
dv/tb_clk_gen.sv
dv/tb_ups.sv

// ==== verilog/ups.sv ====
// -----------------------------------------------
// UPS analog core top level
// Register block, mode control, ADC reader and
// dual DAC writer on one clock
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ups #(
    parameter int SCLK_DIV = 2                          // Serial clock half period
) (
    input  logic                                clk,
    input  logic                                rst,
    // Register writes
    input  logic                                reg_wr,
    input  logic [ups_pkg::REG_ADDR_W-1:0]      reg_addr,
    input  ups_pkg::reg_word_t                  reg_wdata,
    // ADC serial port
    input  logic                                adc_din,
    output logic                                adc_sclk,
    output logic                                adc_cs_n,
    // DAC serial port
    output logic                                dac_sclk,
    output logic                                dac_cs_n,
    output logic                                dac_dout0,
    output logic                                dac_dout1,
    output logic                                valve          // Open drain valve drive
);
    import ups_pkg::*;

    // -----------------------------------------------
    // Internal nets
    // -----------------------------------------------
    mode_e                  mode;
    logic                   mode_dv;
    logic [DATA_W-1:0]      dac0_test;
    logic                   dac0_test_dv;
    logic [DATA_W-1:0]      dac1_test;
    logic                   dac1_test_dv;
    logic [DATA_W-1:0]      adc_data;                   // Latest ADC sample
    logic                   adc_dv;
    logic [DATA_W-1:0]      dac0_data;                  // Codes toward the writer
    logic                   dac0_dv;
    logic [DATA_W-1:0]      dac1_data;
    logic                   dac1_dv;

    ups_regs regs0 (
        .clk          (clk),
        .rst          (rst),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .mode         (mode),
        .mode_dv      (mode_dv),
        .dac0_test    (dac0_test),
        .dac0_test_dv (dac0_test_dv),
        .dac1_test    (dac1_test),
        .dac1_test_dv (dac1_test_dv),
        .valve        (valve)
    );

    ups_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .mode         (mode),
        .mode_dv      (mode_dv),
        .dac0_test    (dac0_test),
        .dac0_test_dv (dac0_test_dv),
        .dac1_test    (dac1_test),
        .dac1_test_dv (dac1_test_dv),
        .adc_data     (adc_data),
        .adc_dv       (adc_dv),
        .dac0_data    (dac0_data),
        .dac0_dv      (dac0_dv),
        .dac1_data    (dac1_data),
        .dac1_dv      (dac1_dv)
    );

    // -----------------------------------------------
    // Converters
    // -----------------------------------------------
    ups_ad #(
        .SCLK_DIV     (SCLK_DIV)
    ) ad0 (
        .clk          (clk),
        .rst          (rst),
        .adc_din      (adc_din),
        .adc_sclk     (adc_sclk),
        .adc_cs_n     (adc_cs_n),
        .adc_data     (adc_data),
        .adc_dv       (adc_dv)
    );

    ups_da #(
        .SCLK_DIV     (SCLK_DIV)
    ) da0 (
        .clk          (clk),
        .rst          (rst),
        .dac0_data    (dac0_data),
        .dac0_dv      (dac0_dv),
        .dac1_data    (dac1_data),
        .dac1_dv      (dac1_dv),
        .dac_sclk     (dac_sclk),
        .dac_cs_n     (dac_cs_n),
        .dac_dout0    (dac_dout0),
        .dac_dout1    (dac_dout1)
    );

endmodule

`default_nettype wire

// ==== verilog/ups_ad.sv ====
// -----------------------------------------------
// UPS serial ADC reader
// Runs back to back 16 clock frames, samples on
// the rising sclk edge, keeps the low 12 bits
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ups_ad #(
    parameter int SCLK_DIV = 2                          // Clocks per sclk half period
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                adc_din,
    output logic                                adc_sclk,      // Idles high
    output logic                                adc_cs_n,
    output logic [ups_pkg::DATA_W-1:0]          adc_data,
    output logic                                adc_dv
);
    import ups_pkg::*;

    localparam int DIV_W  = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam int HALF_N = 2 * FRAME_BITS;             // Half periods with cs low
    localparam int PH_W   = $clog2(HALF_N + 2);         // Frame plus two gap halves

    logic [DIV_W-1:0]       div_cnt;
    logic                   tick;                       // End of a half period
    logic [PH_W-1:0]        ph;                         // Half period index
    logic [PH_W-1:0]        ph_nxt;
    logic                   rise;                       // sclk goes high now
    logic [FRAME_BITS-1:0]  shreg;
    logic                   last_bit;

    assign tick   = (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign ph_nxt = (ph == PH_W'(HALF_N + 1)) ? '0 : ph + 1'b1;
    assign rise   = tick && (ph_nxt < PH_W'(HALF_N)) && ph_nxt[0];

    // -----------------------------------------------
    // Divider and frame sequencing
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt  <= '0;
            ph       <= PH_W'(HALF_N);                  // Start inside the gap
            adc_cs_n <= 1'b1;
            adc_sclk <= 1'b1;
            last_bit <= 1'b0;
            adc_dv   <= 1'b0;
        end else begin
            div_cnt  <= tick ? '0 : div_cnt + 1'b1;
            last_bit <= rise && (ph_nxt == PH_W'(HALF_N - 1));
            adc_dv   <= last_bit;                       // One cycle after last capture
            if (tick) begin
                ph       <= ph_nxt;
                adc_cs_n <= (ph_nxt >= PH_W'(HALF_N));
                // Low on even halves of the frame, sclk and cs fall together
                adc_sclk <= (ph_nxt >= PH_W'(HALF_N)) || ph_nxt[0];
            end
        end
    end

    // -----------------------------------------------
    // Capture
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (rise) begin
            shreg <= {shreg[FRAME_BITS-2:0], adc_din};  // MSB first
        end
        if (last_bit) begin
            adc_data <= shreg[DATA_W-1:0];              // Leading zeros dropped
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ups_ctrl.sv ====
// -----------------------------------------------
// UPS mode control
// Picks the DAC source per mode: register test
// codes, ADC samples with complement, or nothing
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ups_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  ups_pkg::mode_e                      mode,
    input  logic                                mode_dv,
    input  logic [ups_pkg::DATA_W-1:0]          dac0_test,
    input  logic                                dac0_test_dv,
    input  logic [ups_pkg::DATA_W-1:0]          dac1_test,
    input  logic                                dac1_test_dv,
    input  logic [ups_pkg::DATA_W-1:0]          adc_data,
    input  logic                                adc_dv,
    output logic [ups_pkg::DATA_W-1:0]          dac0_data,
    output logic                                dac0_dv,
    output logic [ups_pkg::DATA_W-1:0]          dac1_data,
    output logic                                dac1_dv
);
    import ups_pkg::*;

    mode_e                  act_mode;                   // Mode in force

    // -----------------------------------------------
    // Mode and strobes
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            act_mode <= MODE_IDLE;
            dac0_dv  <= 1'b0;
            dac1_dv  <= 1'b0;
        end else begin
            if (mode_dv) begin
                act_mode <= mode;
            end
            case (act_mode)
                MODE_TEST: begin
                    dac0_dv <= dac0_test_dv;            // Each channel on its own
                    dac1_dv <= dac1_test_dv;
                end
                MODE_FOLLOW: begin
                    dac0_dv <= adc_dv;                  // Both channels at once
                    dac1_dv <= adc_dv;
                end
                default: begin                          // Idle and code 3
                    dac0_dv <= 1'b0;
                    dac1_dv <= 1'b0;
                end
            endcase
        end
    end

    // -----------------------------------------------
    // Codes
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (act_mode == MODE_TEST) begin
            if (dac0_test_dv) begin
                dac0_data <= dac0_test;
            end
            if (dac1_test_dv) begin
                dac1_data <= dac1_test;
            end
        end else if ((act_mode == MODE_FOLLOW) && adc_dv) begin
            dac0_data <= adc_data;                      // Sample as is
            dac1_data <= FULL_SCALE - adc_data;         // Mirrored sample
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ups_da.sv ====
// -----------------------------------------------
// UPS dual channel serial DAC writer
// Holds the newest code per channel and sends both
// in one frame under a shared sclk and chip select
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ups_da #(
    parameter int SCLK_DIV = 2                          // Clocks per sclk half period
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [ups_pkg::DATA_W-1:0]          dac0_data,
    input  logic                                dac0_dv,
    input  logic [ups_pkg::DATA_W-1:0]          dac1_data,
    input  logic                                dac1_dv,
    output logic                                dac_sclk,      // Idles high
    output logic                                dac_cs_n,
    output logic                                dac_dout0,
    output logic                                dac_dout1
);
    import ups_pkg::*;

    localparam int DIV_W  = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam int HALF_N = 2 * FRAME_BITS;             // Half periods with cs low
    localparam int PH_W   = $clog2(HALF_N + 3);

    logic [DATA_W-1:0]      code0;                      // Newest DAC0 code
    logic [DATA_W-1:0]      code1;
    logic                   pending;                    // Frame owed
    logic                   busy;                       // Frame or gap running
    logic                   start;
    logic [DIV_W-1:0]       div_cnt;
    logic                   tick;
    logic [PH_W-1:0]        ph;
    logic [PH_W-1:0]        ph_nxt;
    logic [FRAME_BITS-1:0]  sh0;
    logic [FRAME_BITS-1:0]  sh1;

    assign tick      = (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign ph_nxt    = ph + 1'b1;
    assign start     = !busy && pending;
    assign dac_dout0 = sh0[FRAME_BITS-1];               // MSB drives the line
    assign dac_dout1 = sh1[FRAME_BITS-1];

    // -----------------------------------------------
    // Held codes and pending request
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            code0   <= '0;
            code1   <= '0;
            pending <= 1'b0;
        end else begin
            if (dac0_dv) begin
                code0 <= dac0_data;
            end
            if (dac1_dv) begin
                code1 <= dac1_data;
            end
            if (dac0_dv || dac1_dv) begin
                pending <= 1'b1;                        // Wins over a start
            end else if (start) begin
                pending <= 1'b0;
            end
        end
    end

    // -----------------------------------------------
    // Frame engine
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            div_cnt  <= '0;
            ph       <= '0;
            dac_cs_n <= 1'b1;
            dac_sclk <= 1'b1;
            sh0      <= '0;                             // Lines low between frames
            sh1      <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            div_cnt  <= '0;
            ph       <= '0;
            dac_cs_n <= 1'b0;                           // cs and sclk fall together
            dac_sclk <= 1'b0;
            sh0      <= {{LEAD_BITS{1'b0}}, code0};
            sh1      <= {{LEAD_BITS{1'b0}}, code1};
        end else if (busy) begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                ph       <= ph_nxt;
                dac_cs_n <= (ph_nxt >= PH_W'(HALF_N));
                dac_sclk <= (ph_nxt >= PH_W'(HALF_N)) || ph_nxt[0];
                // Next bit after each fall, zeros once the frame ends
                if (!ph_nxt[0]) begin
                    sh0 <= {sh0[FRAME_BITS-2:0], 1'b0};
                    sh1 <= {sh1[FRAME_BITS-2:0], 1'b0};
                end
                if (ph_nxt == PH_W'(HALF_N + 2)) begin
                    busy <= 1'b0;                       // Gap of one sclk period done
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ups_pkg.sv ====
// -----------------------------------------------
// UPS analog core shared definitions
// Converter widths, serial frame shape, register map
// and the register word views
// -----------------------------------------------
`default_nettype none

package ups_pkg;

    // -----------------------------------------------
    // Converter and frame
    // -----------------------------------------------
    localparam int DATA_W     = 12;                     // Converter code width
    localparam int FRAME_BITS = 16;                     // Serial clocks per frame
    localparam int LEAD_BITS  = 4;                      // Zeros ahead of the code
    localparam logic [DATA_W-1:0] FULL_SCALE = DATA_W'(4095);

    // -----------------------------------------------
    // Register map
    // -----------------------------------------------
    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 2;

    localparam logic [REG_ADDR_W-1:0] REG_MODE  = REG_ADDR_W'(0);
    localparam logic [REG_ADDR_W-1:0] REG_DAC0  = REG_ADDR_W'(1);   // DAC0 test code
    localparam logic [REG_ADDR_W-1:0] REG_DAC1  = REG_ADDR_W'(2);   // DAC1 test code
    localparam logic [REG_ADDR_W-1:0] REG_VALVE = REG_ADDR_W'(3);   // Valve in bit 0

    // Code 3 is not listed and behaves as idle
    typedef enum logic [1:0] {
        MODE_IDLE   = 2'd0,
        MODE_TEST   = 2'd1,                             // DACs take register codes
        MODE_FOLLOW = 2'd2                              // DACs track the ADC
    } mode_e;

    // One register word, read as a mode or as a DAC code
    typedef union packed {
        struct packed {
            logic [REG_W-3:0]      rsvd;
            mode_e                 mode;                // Bits 1:0
        } mode_view;
        struct packed {
            logic [REG_W-DATA_W-1:0] rsvd;
            logic [DATA_W-1:0]       code;              // Bits 11:0
        } code_view;
    } reg_word_t;

endpackage

`default_nettype wire

// ==== verilog/ups_regs.sv ====
// -----------------------------------------------
// UPS register block
// Decodes plain write strobes into the mode, the
// two DAC test codes and the valve bit
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ups_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                reg_wr,        // One cycle write strobe
    input  logic [ups_pkg::REG_ADDR_W-1:0]      reg_addr,
    input  ups_pkg::reg_word_t                  reg_wdata,
    output ups_pkg::mode_e                      mode,
    output logic                                mode_dv,
    output logic [ups_pkg::DATA_W-1:0]          dac0_test,
    output logic                                dac0_test_dv,
    output logic [ups_pkg::DATA_W-1:0]          dac1_test,
    output logic                                dac1_test_dv,
    output logic                                valve
);
    import ups_pkg::*;

    // -----------------------------------------------
    // Control registers and update pulses
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mode         <= MODE_IDLE;
            mode_dv      <= 1'b0;
            dac0_test_dv <= 1'b0;
            dac1_test_dv <= 1'b0;
            valve        <= 1'b0;                       // Valve closed
        end else begin
            mode_dv      <= reg_wr && (reg_addr == REG_MODE);
            dac0_test_dv <= reg_wr && (reg_addr == REG_DAC0);
            dac1_test_dv <= reg_wr && (reg_addr == REG_DAC1);
            if (reg_wr && (reg_addr == REG_MODE)) begin
                mode <= reg_wdata.mode_view.mode;       // Mode view of the word
            end
            if (reg_wr && (reg_addr == REG_VALVE)) begin
                valve <= reg_wdata[0];
            end
        end
    end

    // Test codes, taken through the code view
    always_ff @(posedge clk) begin
        if (reg_wr && (reg_addr == REG_DAC0)) begin
            dac0_test <= reg_wdata.code_view.code;
        end
        if (reg_wr && (reg_addr == REG_DAC1)) begin
            dac1_test <= reg_wdata.code_view.code;
        end
    end

endmodule

`default_nettype wire
